// File: src.f
common/decode_pkg.sv
decode/instr_decoder.sv
hdl/instr_fifo.sv
hdl/decode_frontend.sv
bench/decode_frontend_assert.sv
bench/tb_decode_frontend.sv

// File: Bender.yml
package:
  name: decode_frontend

sources:
  - common/decode_pkg.sv
  - decode/instr_decoder.sv
  - hdl/instr_fifo.sv
  - hdl/decode_frontend.sv
  - target: test
    files:
      - bench/decode_frontend_assert.sv
      - bench/tb_decode_frontend.sv

// File: bench/tb_decode_frontend.sv
`timescale 1ns/1ps

module tb_decode_frontend;

	parameter int DEPTH = 4;

	// major opcodes from the base isa
	localparam logic [6:0] OP_LOAD    = 7'b0000011;
	localparam logic [6:0] OP_FLOAD   = 7'b0000111;
	localparam logic [6:0] OP_MISC    = 7'b0001111;
	localparam logic [6:0] OP_IMM     = 7'b0010011;
	localparam logic [6:0] OP_AUIPC   = 7'b0010111;
	localparam logic [6:0] OP_IMM32   = 7'b0011011;
	localparam logic [6:0] OP_STORE   = 7'b0100011;
	localparam logic [6:0] OP_REG     = 7'b0110011;
	localparam logic [6:0] OP_LUI     = 7'b0110111;
	localparam logic [6:0] OP_REG32   = 7'b0111011;
	localparam logic [6:0] OP_MADD    = 7'b1000011;
	localparam logic [6:0] OP_BRANCH  = 7'b1100011;
	localparam logic [6:0] OP_JALR    = 7'b1100111;
	localparam logic [6:0] OP_JAL     = 7'b1101111;
	localparam logic [6:0] OP_SYSTEM  = 7'b1110011;

	// class groups, 7 means no flag at all
	localparam int G_JUMP = 0;
	localparam int G_BRANCH = 1;
	localparam int G_LOAD = 2;
	localparam int G_STORE = 3;
	localparam int G_ALU_IMM = 4;
	localparam int G_ALU = 5;
	localparam int G_SYS = 6;
	localparam int G_NONE = 7;

	typedef struct packed {
		decode_pkg::instr_t   word;
		decode_pkg::xlen_t    pc;
		logic [2:0]           grp;
		logic [3:0]           idx;
		decode_pkg::xlen_t    imm;
		decode_pkg::reg_idx_t rd;
		decode_pkg::reg_idx_t rs1;
		decode_pkg::reg_idx_t rs2;
		decode_pkg::shamt_t   shamt;
		logic                 illegal;
	} row_t;

	logic                     clk;
	logic                     rst;
	logic                     fetch_valid;
	decode_pkg::instr_t       instr;
	decode_pkg::xlen_t        pc;
	logic                     dispatch_ready;
	logic                     queue_full;
	logic                     out_valid;
	decode_pkg::micro_instr_t out_instr;

	row_t   rows[$];
	row_t   sb[$];
	integer seed;
	logic   hold_ready;
	logic   table_ready;

	decode_frontend #(
		.DEPTH (DEPTH)
	) i_decode_frontend (
		.clk            (clk),
		.rst            (rst),
		.fetch_valid    (fetch_valid),
		.instr          (instr),
		.pc             (pc),
		.dispatch_ready (dispatch_ready),
		.queue_full     (queue_full),
		.out_valid      (out_valid),
		.out_instr      (out_instr)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_failed(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			stop_failed($sformatf("Mismatch at %0t ns: %s got %h expected %h",
				$time, what, got, exp));
		end
	endtask

	// instruction encoders following the isa formats
	function automatic decode_pkg::instr_t enc_r(logic [6:0] f7, decode_pkg::reg_idx_t rs2,
			decode_pkg::reg_idx_t rs1, logic [2:0] f3, decode_pkg::reg_idx_t rd,
			logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic decode_pkg::instr_t enc_i(decode_pkg::xlen_t imm,
			decode_pkg::reg_idx_t rs1, logic [2:0] f3, decode_pkg::reg_idx_t rd,
			logic [6:0] op);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic decode_pkg::instr_t enc_s(decode_pkg::xlen_t imm,
			decode_pkg::reg_idx_t rs2, decode_pkg::reg_idx_t rs1, logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
	endfunction

	function automatic decode_pkg::instr_t enc_b(decode_pkg::xlen_t imm,
			decode_pkg::reg_idx_t rs2, decode_pkg::reg_idx_t rs1, logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
	endfunction

	function automatic decode_pkg::instr_t enc_u(decode_pkg::xlen_t imm,
			decode_pkg::reg_idx_t rd, logic [6:0] op);
		return {imm[31:12], rd, op};
	endfunction

	function automatic decode_pkg::instr_t enc_j(decode_pkg::xlen_t imm,
			decode_pkg::reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
	endfunction

	// register fields and shamt come straight from their bit positions
	task automatic add_row(input decode_pkg::instr_t word, input int grp, input int idx,
			input decode_pkg::xlen_t imm, input decode_pkg::reg_idx_t rd);
		row_t r;
		r.word    = word;
		r.pc      = 64'hffff_ffc0_8000_0000 + 64'(rows.size() * 4);
		r.grp     = grp[2:0];
		r.idx     = idx[3:0];
		r.imm     = imm;
		r.rd      = rd;
		r.rs1     = word[19:15];
		r.rs2     = word[24:20];
		r.shamt   = word[25:20];
		r.illegal = (grp == G_NONE);
		rows.push_back(r);
	endtask

	// one-hot position in {jump, branch, load, store, alu_imm, alu, sys}
	function automatic logic [63:0] class_bits(row_t r);
		int offs[7] = '{0, 4, 10, 17, 21, 34, 49};
		if (r.illegal) begin
			return 64'd0;
		end
		return 64'd1 << (58 - (offs[r.grp] + int'(r.idx)));
	endfunction

	task automatic build_table();
		add_row(enc_u(64'hffff_ffff_abcd_e000, 5'd5, OP_LUI), G_JUMP, 0,
			64'hffff_ffff_abcd_e000, 5'd5);
		add_row(enc_u(64'h1234_5000, 5'd7, OP_AUIPC), G_JUMP, 1, 64'h1234_5000, 5'd7);
		add_row(enc_j(-64'sd1024, 5'd1), G_JUMP, 2, -64'sd1024, 5'd1);
		add_row(enc_j(64'h7_f00a, 5'd31), G_JUMP, 2, 64'h7_f00a, 5'd31);
		add_row(enc_i(-64'sd8, 5'd3, 3'd0, 5'd1, OP_JALR), G_JUMP, 3, -64'sd8, 5'd1);
		add_row(enc_b(-64'sd16, 5'd2, 5'd3, 3'd0), G_BRANCH, 0, -64'sd16, 5'd0);
		add_row(enc_b(64'd4094, 5'd4, 5'd5, 3'd1), G_BRANCH, 1, 64'd4094, 5'd0);
		add_row(enc_b(-64'sd4096, 5'd6, 5'd7, 3'd4), G_BRANCH, 2, -64'sd4096, 5'd0);
		add_row(enc_b(64'd8, 5'd8, 5'd9, 3'd5), G_BRANCH, 3, 64'd8, 5'd0);
		add_row(enc_b(-64'sd2, 5'd10, 5'd11, 3'd6), G_BRANCH, 4, -64'sd2, 5'd0);
		add_row(enc_b(64'd100, 5'd12, 5'd13, 3'd7), G_BRANCH, 5, 64'd100, 5'd0);
		for (int f = 0; f < 7; f++) begin
			add_row(enc_i(64'(f * 300) - 64'd900, 5'(f + 2), 3'(f), 5'(f + 10), OP_LOAD),
				G_LOAD, f, 64'(f * 300) - 64'd900, 5'(f + 10));
		end
		add_row(enc_s(-64'sd1, 5'd4, 5'd2, 3'd0), G_STORE, 0, -64'sd1, 5'd0);
		add_row(enc_s(64'd2047, 5'd5, 5'd3, 3'd1), G_STORE, 1, 64'd2047, 5'd0);
		add_row(enc_s(-64'sd2048, 5'd6, 5'd4, 3'd2), G_STORE, 2, -64'sd2048, 5'd0);
		add_row(enc_s(64'd40, 5'd7, 5'd5, 3'd3), G_STORE, 3, 64'd40, 5'd0);
		add_row(enc_i(-64'sd5, 5'd1, 3'd0, 5'd2, OP_IMM), G_ALU_IMM, 0, -64'sd5, 5'd2);
		add_row(enc_i(64'd12, 5'd3, 3'd0, 5'd4, OP_IMM32), G_ALU_IMM, 1, 64'd12, 5'd4);
		add_row(enc_i(64'd7, 5'd5, 3'd2, 5'd6, OP_IMM), G_ALU_IMM, 2, 64'd7, 5'd6);
		add_row(enc_i(-64'sd7, 5'd7, 3'd3, 5'd8, OP_IMM), G_ALU_IMM, 3, -64'sd7, 5'd8);
		add_row(enc_i(64'h555, 5'd9, 3'd4, 5'd10, OP_IMM), G_ALU_IMM, 4, 64'h555, 5'd10);
		add_row(enc_i(-64'sd256, 5'd11, 3'd6, 5'd12, OP_IMM), G_ALU_IMM, 5, -64'sd256, 5'd12);
		add_row(enc_i(64'h0ff, 5'd13, 3'd7, 5'd14, OP_IMM), G_ALU_IMM, 6, 64'h0ff, 5'd14);
		// shifts carry shamt in the low immediate bits, srai sets bit 10
		add_row(enc_i(64'd37, 5'd15, 3'd1, 5'd16, OP_IMM), G_ALU_IMM, 7, 64'd37, 5'd16);
		add_row(enc_i(64'd13, 5'd17, 3'd1, 5'd18, OP_IMM32), G_ALU_IMM, 8, 64'd13, 5'd18);
		add_row(enc_i(64'd63, 5'd19, 3'd5, 5'd20, OP_IMM), G_ALU_IMM, 9, 64'd63, 5'd20);
		add_row(enc_i(64'd31, 5'd21, 3'd5, 5'd22, OP_IMM32), G_ALU_IMM, 10, 64'd31, 5'd22);
		add_row(enc_i(64'h421, 5'd23, 3'd5, 5'd24, OP_IMM), G_ALU_IMM, 11, 64'h421, 5'd24);
		add_row(enc_i(64'h407, 5'd25, 3'd5, 5'd26, OP_IMM32), G_ALU_IMM, 12, 64'h407, 5'd26);
		add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OP_REG), G_ALU, 0, 64'd0, 5'd3);
		add_row(enc_r(7'h00, 5'd4, 5'd5, 3'd0, 5'd6, OP_REG32), G_ALU, 1, 64'd0, 5'd6);
		add_row(enc_r(7'h20, 5'd7, 5'd8, 3'd0, 5'd9, OP_REG), G_ALU, 2, 64'd0, 5'd9);
		add_row(enc_r(7'h20, 5'd10, 5'd11, 3'd0, 5'd12, OP_REG32), G_ALU, 3, 64'd0, 5'd12);
		add_row(enc_r(7'h00, 5'd13, 5'd14, 3'd1, 5'd15, OP_REG), G_ALU, 4, 64'd0, 5'd15);
		add_row(enc_r(7'h00, 5'd16, 5'd17, 3'd1, 5'd18, OP_REG32), G_ALU, 5, 64'd0, 5'd18);
		add_row(enc_r(7'h00, 5'd19, 5'd20, 3'd2, 5'd21, OP_REG), G_ALU, 6, 64'd0, 5'd21);
		add_row(enc_r(7'h00, 5'd22, 5'd23, 3'd3, 5'd24, OP_REG), G_ALU, 7, 64'd0, 5'd24);
		add_row(enc_r(7'h00, 5'd25, 5'd26, 3'd4, 5'd27, OP_REG), G_ALU, 8, 64'd0, 5'd27);
		add_row(enc_r(7'h00, 5'd28, 5'd29, 3'd5, 5'd30, OP_REG), G_ALU, 9, 64'd0, 5'd30);
		add_row(enc_r(7'h00, 5'd31, 5'd1, 3'd5, 5'd2, OP_REG32), G_ALU, 10, 64'd0, 5'd2);
		add_row(enc_r(7'h20, 5'd3, 5'd4, 3'd5, 5'd5, OP_REG), G_ALU, 11, 64'd0, 5'd5);
		add_row(enc_r(7'h20, 5'd6, 5'd7, 3'd5, 5'd8, OP_REG32), G_ALU, 12, 64'd0, 5'd8);
		add_row(enc_r(7'h00, 5'd9, 5'd10, 3'd6, 5'd11, OP_REG), G_ALU, 13, 64'd0, 5'd11);
		add_row(enc_r(7'h00, 5'd12, 5'd13, 3'd7, 5'd14, OP_REG), G_ALU, 14, 64'd0, 5'd14);
		add_row(enc_i(64'h0ff, 5'd0, 3'd0, 5'd0, OP_MISC), G_SYS, 0, 64'h0ff, 5'd0);
		add_row(enc_i(64'd0, 5'd0, 3'd1, 5'd0, OP_MISC), G_SYS, 1, 64'd0, 5'd0);
		// ecall and ebreak with nonzero rd bits still write no register
		add_row(enc_i(64'd0, 5'd0, 3'd0, 5'd5, OP_SYSTEM), G_SYS, 2, 64'd0, 5'd0);
		add_row(enc_i(64'd1, 5'd0, 3'd0, 5'd9, OP_SYSTEM), G_SYS, 3, 64'd0, 5'd0);
		add_row(enc_i(64'h300, 5'd1, 3'd1, 5'd2, OP_SYSTEM), G_SYS, 4, 64'h300, 5'd2);
		add_row(enc_i(-64'sd1024, 5'd3, 3'd2, 5'd4, OP_SYSTEM), G_SYS, 5, -64'sd1024, 5'd4);
		add_row(enc_i(64'h341, 5'd5, 3'd3, 5'd6, OP_SYSTEM), G_SYS, 6, 64'h341, 5'd6);
		add_row(enc_i(64'h305, 5'd7, 3'd5, 5'd8, OP_SYSTEM), G_SYS, 7, 64'h305, 5'd8);
		add_row(enc_i(-64'sd236, 5'd9, 3'd6, 5'd10, OP_SYSTEM), G_SYS, 8, -64'sd236, 5'd10);
		add_row(enc_i(64'h7c0, 5'd11, 3'd7, 5'd12, OP_SYSTEM), G_SYS, 9, 64'h7c0, 5'd12);
		// unsupported words: flw, a mul funct7 on op, madd
		add_row(enc_i(64'd16, 5'd2, 3'd2, 5'd3, OP_FLOAD), G_NONE, 0, 64'd0, 5'd3);
		add_row(enc_r(7'h01, 5'd4, 5'd5, 3'd0, 5'd6, OP_REG), G_NONE, 0, 64'd0, 5'd6);
		add_row(enc_r(7'h10, 5'd7, 5'd8, 3'd0, 5'd9, OP_MADD), G_NONE, 0, 64'd0, 5'd9);
	endtask

	// hold fetch on the row while the queue is full
	task automatic send_row(input row_t r);
		@(negedge clk);
		fetch_valid = 1'b1;
		instr       = r.word;
		pc          = r.pc;
		while (queue_full) begin
			@(negedge clk);
		end
		sb.push_back(r);
	endtask

	task automatic wait_drained();
		@(negedge clk);
		fetch_valid = 1'b0;
		while (sb.size() != 0) begin
			@(negedge clk);
		end
		check_value("out_valid after drain", out_valid, 1'b0);
	endtask

	always @(negedge clk) begin
		dispatch_ready = hold_ready ? 1'b0 : $random(seed) & 1;
	end

	// scoreboard compare on every pop
	always @(posedge clk) begin
		row_t exp;
		if (!rst && out_valid && dispatch_ready) begin
			if (sb.size() == 0) begin
				stop_failed("Queue popped an entry that was never accepted");
			end
			exp = sb.pop_front();
			check_value("class flags", {out_instr.jump, out_instr.branch, out_instr.load,
				out_instr.store, out_instr.alu_imm, out_instr.alu, out_instr.sys},
				class_bits(exp));
			check_value("illegal", out_instr.illegal, exp.illegal);
			check_value("pc", out_instr.pc, exp.pc);
			check_value("imm", out_instr.imm, exp.imm);
			check_value("shamt", out_instr.shamt, exp.shamt);
			check_value("rd", out_instr.rd, exp.rd);
			check_value("rs1", out_instr.rs1, exp.rs1);
			check_value("rs2", out_instr.rs2, exp.rs2);
		end
	end

	// the limit depends on the table length, so start once the table exists
	initial begin
		wait (table_ready);
		#((rows.size() + DEPTH + 2) * 40 * 100 + 4 * 100);
		stop_failed("Timeout: the run did not finish in the expected number of cycles");
	end

	initial begin
		seed           = 57438;
		rst            = 1'b1;
		fetch_valid    = 1'b0;
		instr          = '0;
		pc             = '0;
		hold_ready     = 1'b0;
		dispatch_ready = 1'b0;
		table_ready    = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_value("out_valid after reset", out_valid, 1'b0);
		check_value("queue_full after reset", queue_full, 1'b0);

		foreach (rows[i]) begin
			send_row(rows[i]);
		end
		wait_drained();

		// back-pressure until the queue fills, then release
		@(posedge clk);
		hold_ready = 1'b1;
		fork
			begin
				for (int k = 0; k < DEPTH + 2; k++) begin
					send_row(rows[k]);
				end
			end
			begin
				@(negedge clk);
				while (!queue_full) begin
					@(negedge clk);
				end
				repeat (3) @(negedge clk);
				check_value("queue_full under back-pressure", queue_full, 1'b1);
				check_value("entries held", sb.size(), DEPTH);
				@(posedge clk);
				hold_ready = 1'b0;
			end
		join
		wait_drained();

		$display("Testbench passed");
		$finish;
	end

endmodule

// File: bench/decode_frontend_assert.sv
`timescale 1ns/1ps

module decode_frontend_assert (
	input logic                     clk,
	input logic                     rst,
	input logic                     push,
	input logic                     pop_ready,
	input logic                     full,
	input logic                     valid,
	input decode_pkg::micro_instr_t rd_data
);

	// decoder must gate push with full
	a_no_push_when_full: assert property (
		@(posedge clk) disable iff (rst) !(push && full)
	) else $error("push while queue full");

	// without a pop the head stays valid
	a_valid_holds: assert property (
		@(posedge clk) disable iff (rst) (valid && !pop_ready) |=> valid
	) else $error("valid dropped without a pop");

	a_head_stable: assert property (
		@(posedge clk) disable iff (rst) (valid && !pop_ready) |=> $stable(rd_data)
	) else $error("head entry changed while stalled");

endmodule

bind instr_fifo decode_frontend_assert i_decode_frontend_assert (
	.clk       (clk),
	.rst       (rst),
	.push      (push),
	.pop_ready (pop_ready),
	.full      (full),
	.valid     (valid),
	.rd_data   (rd_data)
);

// File: hdl/decode_frontend.sv
`timescale 1ns/1ps

module decode_frontend #(
	parameter int DEPTH = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     fetch_valid,
	input  decode_pkg::instr_t       instr,
	input  decode_pkg::xlen_t        pc,
	input  logic                     dispatch_ready,
	output logic                     queue_full,
	output logic                     out_valid,
	output decode_pkg::micro_instr_t out_instr
);

	decode_pkg::micro_instr_t micro_instr;
	logic                     push;

	// combinational decode, push only when the queue has room
	instr_decoder i_instr_decoder (
		.instr       (instr),
		.fetch_valid (fetch_valid),
		.pc          (pc),
		.queue_full  (queue_full),
		.micro_instr (micro_instr),
		.push        (push)
	);

	// decoded entries wait here until issue takes them
	instr_fifo #(
		.DEPTH (DEPTH)
	) i_instr_fifo (
		.clk       (clk),
		.rst       (rst),
		.push      (push),
		.wr_data   (micro_instr),
		.pop_ready (dispatch_ready),
		.rd_data   (out_instr),
		.full      (queue_full),
		.valid     (out_valid)
	);

endmodule

// File: hdl/instr_fifo.sv
`timescale 1ns/1ps

module instr_fifo #(
	parameter int DEPTH = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     push,
	input  decode_pkg::micro_instr_t wr_data,
	input  logic                     pop_ready,
	output decode_pkg::micro_instr_t rd_data,
	output logic                     full,
	output logic                     valid
);

	localparam int AW = $clog2(DEPTH);

	// depth must be a power of two so the pointer wrap bit works
	if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
		$error("instr_fifo: DEPTH must be a power of two of at least 2");
	end

	decode_pkg::micro_instr_t mem [DEPTH];

	// one extra bit tells a full queue from an empty one
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        empty;
	logic        pop;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign valid = ~empty;
	assign pop   = valid & pop_ready;

	// push is already gated by full in the decoder
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
		end else if (push) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
		end else if (pop) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr[AW-1:0]] <= wr_data;
		end
	end

	// head entry straight from the array
	assign rd_data = mem[rd_ptr[AW-1:0]];

endmodule

// File: decode/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
	input  decode_pkg::instr_t       instr,
	input  logic                     fetch_valid,
	input  decode_pkg::xlen_t        pc,
	input  logic                     queue_full,
	output decode_pkg::micro_instr_t micro_instr,
	output logic                     push
);

	// funct7 values used by the base integer set
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;
	// upper six bits of funct7 for the rv64 shift-immediate forms
	localparam logic [5:0] F6_SRL  = 6'b000000;
	localparam logic [5:0] F6_SRA  = 6'b010000;

	// opcode split into its fields
	logic [1:0] opc_lo;
	logic [2:0] opc_mid;
	logic [1:0] opc_hi;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [7:0] f3;
	logic       f7_base;
	logic       f7_alt;
	logic       is_32bit;

	// major opcodes
	logic op_load;
	logic op_misc_mem;
	logic op_op_imm;
	logic op_auipc;
	logic op_op_imm32;
	logic op_store;
	logic op_op;
	logic op_lui;
	logic op_op_32;
	logic op_branch;
	logic op_jalr;
	logic op_jal;
	logic op_system;

	decode_pkg::jump_op_t    jump;
	decode_pkg::branch_op_t  branch;
	decode_pkg::load_op_t    load;
	decode_pkg::store_op_t   store;
	decode_pkg::alu_imm_op_t alu_imm;
	decode_pkg::alu_op_t     alu;
	decode_pkg::sys_op_t     sys;

	decode_pkg::xlen_t imm_i;
	decode_pkg::xlen_t imm_s;
	decode_pkg::xlen_t imm_b;
	decode_pkg::xlen_t imm_u;
	decode_pkg::xlen_t imm_j;
	decode_pkg::xlen_t imm;
	logic              fmt_i;
	logic              fmt_s;
	logic              fmt_b;
	logic              fmt_u;
	logic              fmt_j;
	logic              no_rd;

	assign opc_lo  = instr[1:0];
	assign opc_mid = instr[4:2];
	assign opc_hi  = instr[6:5];
	assign funct3  = instr[14:12];
	assign funct7  = instr[31:25];

	// one-hot funct3
	assign f3      = 8'b1 << funct3;
	assign f7_base = (funct7 == F7_BASE);
	assign f7_alt  = (funct7 == F7_ALT);

	// compressed words (low bits not 11) never match
	assign is_32bit = (opc_lo == 2'b11);

	assign op_load     = is_32bit & (opc_hi == 2'b00) & (opc_mid == 3'b000);
	assign op_misc_mem = is_32bit & (opc_hi == 2'b00) & (opc_mid == 3'b011);
	assign op_op_imm   = is_32bit & (opc_hi == 2'b00) & (opc_mid == 3'b100);
	assign op_auipc    = is_32bit & (opc_hi == 2'b00) & (opc_mid == 3'b101);
	assign op_op_imm32 = is_32bit & (opc_hi == 2'b00) & (opc_mid == 3'b110);
	assign op_store    = is_32bit & (opc_hi == 2'b01) & (opc_mid == 3'b000);
	assign op_op       = is_32bit & (opc_hi == 2'b01) & (opc_mid == 3'b100);
	assign op_lui      = is_32bit & (opc_hi == 2'b01) & (opc_mid == 3'b101);
	assign op_op_32    = is_32bit & (opc_hi == 2'b01) & (opc_mid == 3'b110);
	assign op_branch   = is_32bit & (opc_hi == 2'b11) & (opc_mid == 3'b000);
	assign op_jalr     = is_32bit & (opc_hi == 2'b11) & (opc_mid == 3'b001);
	assign op_jal      = is_32bit & (opc_hi == 2'b11) & (opc_mid == 3'b011);
	assign op_system   = is_32bit & (opc_hi == 2'b11) & (opc_mid == 3'b100);

	always_comb begin
		jump.lui   = op_lui;
		jump.auipc = op_auipc;
		jump.jal   = op_jal;
		jump.jalr  = op_jalr & f3[0];

		branch.beq  = op_branch & f3[0];
		branch.bne  = op_branch & f3[1];
		branch.blt  = op_branch & f3[4];
		branch.bge  = op_branch & f3[5];
		branch.bltu = op_branch & f3[6];
		branch.bgeu = op_branch & f3[7];

		load.lb  = op_load & f3[0];
		load.lh  = op_load & f3[1];
		load.lw  = op_load & f3[2];
		load.ld  = op_load & f3[3];
		load.lbu = op_load & f3[4];
		load.lhu = op_load & f3[5];
		load.lwu = op_load & f3[6];

		store.sb = op_store & f3[0];
		store.sh = op_store & f3[1];
		store.sw = op_store & f3[2];
		store.sd = op_store & f3[3];
	end

	// shamt[5] sits in funct7[0], so rv64 shifts only check the upper six bits
	always_comb begin
		alu_imm.addi  = op_op_imm & f3[0];
		alu_imm.addiw = op_op_imm32 & f3[0];
		alu_imm.slti  = op_op_imm & f3[2];
		alu_imm.sltiu = op_op_imm & f3[3];
		alu_imm.xori  = op_op_imm & f3[4];
		alu_imm.ori   = op_op_imm & f3[6];
		alu_imm.andi  = op_op_imm & f3[7];
		alu_imm.slli  = op_op_imm & f3[1] & (funct7[6:1] == F6_SRL);
		alu_imm.slliw = op_op_imm32 & f3[1] & f7_base;
		alu_imm.srli  = op_op_imm & f3[5] & (funct7[6:1] == F6_SRL);
		alu_imm.srliw = op_op_imm32 & f3[5] & f7_base;
		alu_imm.srai  = op_op_imm & f3[5] & (funct7[6:1] == F6_SRA);
		alu_imm.sraiw = op_op_imm32 & f3[5] & f7_alt;
	end

	always_comb begin
		alu.add  = op_op & f3[0] & f7_base;
		alu.addw = op_op_32 & f3[0] & f7_base;
		alu.sub  = op_op & f3[0] & f7_alt;
		alu.subw = op_op_32 & f3[0] & f7_alt;
		alu.sll  = op_op & f3[1] & f7_base;
		alu.sllw = op_op_32 & f3[1] & f7_base;
		alu.slt  = op_op & f3[2] & f7_base;
		alu.sltu = op_op & f3[3] & f7_base;
		alu.xor_ = op_op & f3[4] & f7_base;
		alu.srl  = op_op & f3[5] & f7_base;
		alu.srlw = op_op_32 & f3[5] & f7_base;
		alu.sra  = op_op & f3[5] & f7_alt;
		alu.sraw = op_op_32 & f3[5] & f7_alt;
		alu.or_  = op_op & f3[6] & f7_base;
		alu.and_ = op_op & f3[7] & f7_base;
	end

	// ecall and ebreak differ only in the funct12 field
	always_comb begin
		sys.fence   = op_misc_mem & f3[0];
		sys.fence_i = op_misc_mem & f3[1];
		sys.ecall   = op_system & f3[0] & (instr[31:20] == 12'h000);
		sys.ebreak  = op_system & f3[0] & (instr[31:20] == 12'h001);
		sys.csrrw   = op_system & f3[1];
		sys.csrrs   = op_system & f3[2];
		sys.csrrc   = op_system & f3[3];
		sys.csrrwi  = op_system & f3[5];
		sys.csrrsi  = op_system & f3[6];
		sys.csrrci  = op_system & f3[7];
	end

	// immediates per format, all sign-extended from bit 31
	assign imm_i = {{52{instr[31]}}, instr[31:20]};
	assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
	assign imm_j = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	assign fmt_i = jump.jalr | (|load) | (|alu_imm) | sys.fence | sys.fence_i
		| sys.csrrw | sys.csrrs | sys.csrrc | sys.csrrwi | sys.csrrsi | sys.csrrci;
	assign fmt_s = |store;
	assign fmt_b = |branch;
	assign fmt_u = jump.lui | jump.auipc;
	assign fmt_j = jump.jal;

	// formats are mutually exclusive, r-type and the rest fall through to zero
	always_comb begin
		if (fmt_i) begin
			imm = imm_i;
		end else if (fmt_s) begin
			imm = imm_s;
		end else if (fmt_b) begin
			imm = imm_b;
		end else if (fmt_u) begin
			imm = imm_u;
		end else if (fmt_j) begin
			imm = imm_j;
		end else begin
			imm = '0;
		end
	end

	// these write no register
	assign no_rd = (|branch) | (|store) | sys.ecall | sys.ebreak;

	always_comb begin
		micro_instr.jump    = jump;
		micro_instr.branch  = branch;
		micro_instr.load    = load;
		micro_instr.store   = store;
		micro_instr.alu_imm = alu_imm;
		micro_instr.alu     = alu;
		micro_instr.sys     = sys;
		micro_instr.illegal = ~|{jump, branch, load, store, alu_imm, alu, sys};
		micro_instr.pc      = pc;
		micro_instr.imm     = imm;
		micro_instr.shamt   = instr[25:20];
		micro_instr.rd      = no_rd ? 5'd0 : instr[11:7];
		micro_instr.rs1     = instr[19:15];
		micro_instr.rs2     = instr[24:20];
	end

	assign push = fetch_valid & ~queue_full;

endmodule

// File: common/decode_pkg.sv
package decode_pkg;

	// architectural widths
	localparam int ILEN    = 32;
	localparam int XLEN    = 64;
	localparam int REG_W   = 5;
	localparam int SHAMT_W = 6;

	typedef logic [ILEN-1:0]    instr_t;
	typedef logic [XLEN-1:0]    xlen_t;
	typedef logic [REG_W-1:0]   reg_idx_t;
	typedef logic [SHAMT_W-1:0] shamt_t;

	// upper immediates and jumps
	typedef struct packed {
		logic lui, auipc, jal, jalr;
	} jump_op_t;

	// conditional branches
	typedef struct packed {
		logic beq, bne, blt, bge, bltu, bgeu;
	} branch_op_t;

	typedef struct packed {
		logic lb, lh, lw, ld, lbu, lhu, lwu;
	} load_op_t;

	typedef struct packed {
		logic sb, sh, sw, sd;
	} store_op_t;

	// register-immediate arithmetic, shifts last
	typedef struct packed {
		logic addi, addiw, slti, sltiu, xori, ori, andi;
		logic slli, slliw, srli, srliw, srai, sraiw;
	} alu_imm_op_t;

	// register-register arithmetic
	// xor, or and and are reserved words, hence the trailing underscore
	typedef struct packed {
		logic add, addw, sub, subw, sll, sllw, slt, sltu;
		logic xor_, srl, srlw, sra, sraw, or_, and_;
	} alu_op_t;

	// fences, environment calls and csr access
	typedef struct packed {
		logic fence, fence_i, ecall, ebreak;
		logic csrrw, csrrs, csrrc, csrrwi, csrrsi, csrrci;
	} sys_op_t;

	// one decoded instruction as it sits in the instruction queue
	typedef struct packed {
		jump_op_t    jump;
		branch_op_t  branch;
		load_op_t    load;
		store_op_t   store;
		alu_imm_op_t alu_imm;
		alu_op_t     alu;
		sys_op_t     sys;
		// no class flag matched
		logic        illegal;
		xlen_t       pc;
		xlen_t       imm;
		shamt_t      shamt;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
	} micro_instr_t;

endpackage
